// File: hdl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] pc_t;

    // decode stage flags seen by fetch
    typedef struct packed {
        logic redirect;     // load target now
        logic jalr;         // hold, target follows a cycle later
        logic lsu_pending;  // load or store in flight
        logic mul_busy;
        logic div_busy;
        logic mul_done;     // pulse
        logic div_done;     // pulse
        pc_t  target;
    } decode_status_t;

    // memory and writeback completion strobes
    typedef struct packed {
        logic mem_done;
        logic wb_done;
    } mem_status_t;

endpackage

`default_nettype wire

// File: hdl/bus_pkg.sv
`default_nettype none

package bus_pkg;

    localparam int id_width = 4;

    typedef logic [id_width-1:0] bus_id_t;

    // instruction read request, held until the address is taken
    typedef struct packed {
        logic         valid;
        bus_id_t      id;
        cpu_pkg::pc_t addr;
    } fetch_req_t;

    // read channel status from the bus
    typedef struct packed {
        logic                     ar_hs;   // address accepted
        logic                     r_done;  // data returned
        bus_id_t                  id;
        logic [cpu_pkg::xlen-1:0] data;
    } read_rsp_t;

endpackage

`default_nettype wire

// File: hdl/fetch_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_sequencer #(
    parameter bus_pkg::bus_id_t fetch_id = 4'd1
) (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     lsu_pending,
    input  wire cpu_pkg::mem_status_t     mem,
    input  wire bus_pkg::read_rsp_t       rsp,
    input  wire cpu_pkg::pc_t             pc,
    output bus_pkg::fetch_req_t           req,
    output logic                          fetch_done,
    output logic                          instr_valid,
    output logic [31:0]                   instr
);

    typedef enum logic [2:0] {
        s_idle,
        s_mem_wait,
        s_wb_wait,
        s_settle,
        s_request,
        s_data,
        s_finish
    } state_t;

    state_t state;
    state_t state_next;
    logic   id_match;

    // responses for other masters carry other ids
    assign id_match = (rsp.id == fetch_id);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= s_idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            s_idle: begin
                if (lsu_pending) begin
                    state_next = s_mem_wait;
                end else begin
                    state_next = s_settle;
                end
            end
            s_mem_wait: begin
                if (mem.mem_done) begin
                    state_next = s_wb_wait;
                end
            end
            s_wb_wait: begin
                if (mem.wb_done) begin
                    state_next = s_settle;
                end
            end
            s_settle: begin
                state_next = s_request;
            end
            s_request: begin
                if (rsp.ar_hs && id_match) begin
                    state_next = s_data;
                end
            end
            s_data: begin
                if (rsp.r_done && id_match) begin
                    state_next = s_finish;
                end
            end
            s_finish: begin
                state_next = s_idle;  // one idle cycle between fetches
            end
            default: begin
                state_next = s_idle;
            end
        endcase
    end

    // fetched word
    always_ff @(posedge clk) begin
        if (state == s_data && rsp.r_done && id_match) begin
            instr <= rsp.data;
        end
    end

    always_comb begin
        req.valid = (state == s_request);
        req.addr  = pc;
        if (state == s_request || state == s_data) begin
            req.id = fetch_id;
        end else begin
            req.id = '0;
        end
    end

    assign fetch_done  = (state == s_finish);
    assign instr_valid = (state == s_finish);  // instr is valid alongside

endmodule

`default_nettype wire

// File: hdl/muldiv_hold.sv
`timescale 1ns/1ps
`default_nettype none

module muldiv_hold (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire cpu_pkg::decode_status_t dec,
    input  wire logic                    fetch_done,
    output logic                         md_hold,
    output logic                         md_advance
);

    typedef enum logic [1:0] {
        md_idle,
        md_busy,
        md_after,   // unit finished, next fetch still out
        md_end
    } md_state_t;

    md_state_t state;
    md_state_t state_next;
    logic      fetch_seen;  // next fetch came back before the unit
    logic      unit_done;

    assign unit_done = dec.mul_done | dec.div_done;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= md_idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            md_idle: begin
                if (dec.mul_busy || dec.div_busy) begin
                    state_next = md_busy;
                end
            end
            md_busy: begin
                if (unit_done && (fetch_done || fetch_seen)) begin
                    state_next = md_end;
                end else if (unit_done) begin
                    state_next = md_after;
                end
            end
            md_after: begin
                if (fetch_done) begin
                    state_next = md_end;
                end
            end
            default: begin
                state_next = md_idle;  // md_end lasts one cycle
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_seen <= 1'b0;
        end else if (state == md_busy) begin
            fetch_seen <= fetch_seen | fetch_done;
        end else begin
            fetch_seen <= 1'b0;
        end
    end

    assign md_hold    = (state != md_idle);
    assign md_advance = (state == md_end) && !dec.redirect;  // redirect wins

endmodule

`default_nettype wire

// File: hdl/pc_update.sv
`timescale 1ns/1ps
`default_nettype none

module pc_update #(
    parameter cpu_pkg::pc_t reset_pc = 32'h8000_0000
) (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire cpu_pkg::decode_status_t dec,
    input  wire logic                    fetch_done,
    input  wire logic                    md_hold,
    input  wire logic                    md_advance,
    output cpu_pkg::pc_t                 pc
);

    import cpu_pkg::*;

    localparam pc_t pc_step = pc_t'(4);

    typedef enum logic [1:0] {
        sel_keep,
        sel_target,
        sel_step
    } pc_sel_t;

    pc_sel_t sel;
    pc_t     pc_next;
    logic    jalr_q;    // jalr seen last cycle

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            jalr_q <= 1'b0;
        end else begin
            jalr_q <= dec.jalr;
        end
    end

    // one rule per clock, highest first
    always_comb begin
        if (dec.redirect) begin
            sel = sel_target;
        end else if (dec.jalr) begin
            sel = sel_keep;
        end else if (jalr_q) begin
            sel = sel_target;       // jalr target resolved by now
        end else if (md_advance) begin
            sel = sel_step;
        end else if (fetch_done && !md_hold) begin
            sel = sel_step;
        end else begin
            sel = sel_keep;
        end
    end

    always_comb begin
        case (sel)
            sel_target: begin
                pc_next = dec.target;
            end
            sel_step: begin
                pc_next = pc + pc_step;
            end
            default: begin
                pc_next = pc;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= reset_pc;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

`default_nettype wire

// File: hdl/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
    parameter cpu_pkg::pc_t     reset_pc = 32'h8000_0000,
    parameter bus_pkg::bus_id_t fetch_id = 4'd1
) (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire cpu_pkg::decode_status_t dec,
    input  wire cpu_pkg::mem_status_t    mem,
    input  wire bus_pkg::read_rsp_t      rsp,
    output bus_pkg::fetch_req_t          req,
    output cpu_pkg::pc_t                 pc,
    output logic                         instr_valid,
    output logic [31:0]                  instr
);

    logic fetch_done;   // one cycle after the matching r_done
    logic md_hold;
    logic md_advance;

    fetch_sequencer #(
        .fetch_id(fetch_id)
    ) seq0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .lsu_pending(dec.lsu_pending),
        .mem        (mem),
        .rsp        (rsp),
        .pc         (pc),
        .req        (req),
        .fetch_done (fetch_done),
        .instr_valid(instr_valid),
        .instr      (instr)
    );

    muldiv_hold hold0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .dec       (dec),
        .fetch_done(fetch_done),
        .md_hold   (md_hold),
        .md_advance(md_advance)
    );

    pc_update #(
        .reset_pc(reset_pc)
    ) pcu0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .dec       (dec),
        .fetch_done(fetch_done),
        .md_hold   (md_hold),
        .md_advance(md_advance),
        .pc        (pc)
    );

endmodule

`default_nettype wire

// File: testbench/fetch_unit_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit_assertions #(
    parameter bus_pkg::bus_id_t fetch_id = 4'd1
) (
    input wire logic                clk,
    input wire logic                rst_n,
    input wire bus_pkg::fetch_req_t req,
    input wire bus_pkg::read_rsp_t  rsp,
    input wire logic                instr_valid
);

    logic accepted;

    assign accepted = rsp.ar_hs && (rsp.id == fetch_id);

    // request held with a fixed address until our id is accepted
    req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        req.valid && !accepted |=> req.valid && $stable(req.addr))
        else $error("fetch request dropped or moved before address acceptance");

    // one pulse, right after our own read data
    instr_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        instr_valid |-> !$past(instr_valid) && $past(rsp.r_done && rsp.id == fetch_id))
        else $error("instr_valid not a single pulse after matching read data");

    reset_idle: assert property (@(posedge clk) !rst_n |=> !req.valid)
        else $error("fetch request valid right after reset");

endmodule

`default_nettype wire

// File: testbench/fetch_checker.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_checker #(
    parameter cpu_pkg::pc_t     reset_pc = 32'h8000_0000,
    parameter bus_pkg::bus_id_t fetch_id = 4'd1
) (
    input wire logic                    clk,
    input wire logic                    rst_n,
    input wire cpu_pkg::decode_status_t dec,
    input wire cpu_pkg::mem_status_t    mem,
    input wire bus_pkg::read_rsp_t      rsp,
    input wire bus_pkg::fetch_req_t     req,
    input wire cpu_pkg::pc_t            pc,
    input wire logic                    instr_valid,
    input wire logic [31:0]             instr
);

    import cpu_pkg::*;

    typedef enum int {m_idle, m_busy, m_after, m_end} md_ref_t;

    int      errors = 0;
    int      checks = 0;
    int      tests = 0;
    int      errs_mark = 0;
    pc_t     exp_pc;
    logic    exp_iv;
    logic    jalr_q;
    md_ref_t md_st;
    logic    fseen;
    logic    data_ph;    // address taken, data still out
    pc_t     data_addr;
    pc_t     ret_addr;
    logic    lsu_gate;   // no request allowed while set
    logic    mem_seen;
    logic    adv;
    logic    hold;
    logic    match;

    function automatic pc_t next_pc(input pc_t cur, input decode_status_t d, input logic jq,
                                    input logic md_adv, input logic fd, input logic md_h);
        if (d.redirect) return d.target;
        if (d.jalr) return cur;
        if (jq) return d.target;
        if (md_adv) return cur + 32'd4;
        if (fd && !md_h) return cur + 32'd4;
        return cur;
    endfunction

    function automatic logic [31:0] expected_word(input pc_t a);
        return {a[15:0], a[31:16]} ^ 32'h1357_9bdf;
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("test %0d %s: %s (%0d errors)", tests, name,
                 (errors == errs_mark) ? "ok" : "failed", errors - errs_mark);
        errs_mark = errors;
    endtask

    task automatic report_counts();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    endtask

    // sample between edges, inputs here are what the next edge sees
    always @(negedge clk) begin
        if (!rst_n) begin
            exp_pc = reset_pc;
            exp_iv = 1'b0;
            jalr_q = 1'b0;
            md_st = m_idle;
            fseen = 1'b0;
            data_ph = 1'b0;
            data_addr = '0;
            ret_addr = '0;
            lsu_gate = 1'b0;
            mem_seen = 1'b0;
        end else begin
            compare("pc", pc, exp_pc);
            if (req.valid) begin
                compare("req.addr", req.addr, exp_pc);  // fetch goes to the current pc
                compare("req.id", 32'(req.id), 32'(fetch_id));
            end
            compare("instr_valid", 32'(instr_valid), 32'(exp_iv));
            if (exp_iv) compare("instr", instr, expected_word(ret_addr));
            if (lsu_gate && req.valid) begin
                errors++;
                $display("fetch request issued while a load or store was still pending");
            end
            hold = (md_st != m_idle);
            adv = (md_st == m_end) && !dec.redirect;
            match = (rsp.id == fetch_id);
            exp_pc = next_pc(exp_pc, dec, jalr_q, adv, exp_iv, hold);
            case (md_st)
                m_idle: if (dec.mul_busy || dec.div_busy) md_st = m_busy;
                m_busy: begin
                    if ((dec.mul_done || dec.div_done) && (exp_iv || fseen)) md_st = m_end;
                    else if (dec.mul_done || dec.div_done) md_st = m_after;
                end
                m_after: if (exp_iv) md_st = m_end;
                default: md_st = m_idle;
            endcase
            fseen = hold && !adv && (md_st == m_busy) ? (fseen | exp_iv) : 1'b0;
            jalr_q = dec.jalr;
            exp_iv = data_ph && rsp.r_done && match;
            if (exp_iv) ret_addr = data_addr;
            if (req.valid && rsp.ar_hs && match) begin
                data_ph = 1'b1;
                data_addr = req.addr;
            end else if (exp_iv) begin
                data_ph = 1'b0;
            end
            if (lsu_gate) begin
                if (mem.mem_done) mem_seen = 1'b1;
                if (mem_seen && mem.wb_done) begin
                    lsu_gate = 1'b0;
                    mem_seen = 1'b0;
                end
            end else if (dec.lsu_pending && !req.valid && !data_ph) begin
                lsu_gate = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_unit;

    import cpu_pkg::*;
    import bus_pkg::*;

    localparam pc_t     reset_pc = 32'h8000_0000;
    localparam bus_id_t fetch_id = 4'd1;
    localparam int      limit = 200;

    logic           clk;
    logic           rst_n;
    decode_status_t dec;
    mem_status_t    mem;
    read_rsp_t      rsp;
    fetch_req_t     req;
    pc_t            pc;
    logic           instr_valid;
    logic [31:0]    instr;
    int             stall = 0;       // extra bus delay
    logic           force_foreign = 1'b0;
    int             bstate;
    int             cnt;
    logic           foreign;
    pc_t            addr_l;

    fetch_unit #(.reset_pc(reset_pc), .fetch_id(fetch_id)) dut0 (
        .clk(clk), .rst_n(rst_n), .dec(dec), .mem(mem), .rsp(rsp),
        .req(req), .pc(pc), .instr_valid(instr_valid), .instr(instr)
    );

    fetch_checker #(.reset_pc(reset_pc), .fetch_id(fetch_id)) chk0 (
        .clk(clk), .rst_n(rst_n), .dec(dec), .mem(mem), .rsp(rsp),
        .req(req), .pc(pc), .instr_valid(instr_valid), .instr(instr)
    );

    bind fetch_sequencer fetch_unit_assertions #(.fetch_id(fetch_id)) asrt0 (
        .clk(clk), .rst_n(rst_n), .req(req), .rsp(rsp), .instr_valid(instr_valid)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] bus_word(input pc_t a);
        return {a[15:0], a[31:16]} ^ 32'h1357_9bdf;
    endfunction

    // bus responder, sometimes answers another master's id first
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bstate <= 0;
            rsp <= '0;
            cnt <= 0;
            foreign <= 1'b0;
            addr_l <= '0;
        end else begin
            rsp <= '0;
            case (bstate)
                0: if (req.valid) begin
                    cnt <= int'($urandom % 4) + stall;
                    foreign <= force_foreign | (($urandom % 4) == 0);
                    bstate <= 1;
                end
                1: if (cnt != 0) begin
                    cnt <= cnt - 1;
                end else if (foreign) begin
                    rsp.ar_hs <= 1'b1;
                    rsp.id <= 4'd5;
                    foreign <= 1'b0;
                end else begin
                    rsp.ar_hs <= 1'b1;
                    rsp.id <= fetch_id;
                    addr_l <= req.addr;
                    cnt <= int'($urandom % 4) + stall;
                    foreign <= force_foreign | (($urandom % 4) == 0);
                    bstate <= 2;
                end
                default: if (cnt != 0) begin
                    cnt <= cnt - 1;
                end else if (foreign) begin
                    rsp.r_done <= 1'b1;
                    rsp.id <= 4'd9;
                    rsp.data <= 32'hdead_beef;
                    foreign <= 1'b0;
                end else begin
                    rsp.r_done <= 1'b1;
                    rsp.id <= fetch_id;
                    rsp.data <= bus_word(addr_l);
                    bstate <= 0;
                end
            endcase
        end
    end

    task automatic abort(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $finish;
    endtask

    // returns on the edge that sees instr_valid
    task automatic wait_instr();
        int n;
        n = 0;
        @(posedge clk);
        while (!instr_valid && n <= limit) begin
            n++;
            @(posedge clk);
        end
        if (!instr_valid) abort("timed out waiting for an instruction to return");
    endtask

    // returns on the edge that sees our r_done, fetch_done follows
    task automatic wait_data();
        int n;
        n = 0;
        @(posedge clk);
        while (!(rsp.r_done && rsp.id == fetch_id) && n <= limit) begin
            n++;
            @(posedge clk);
        end
        if (!(rsp.r_done && rsp.id == fetch_id)) abort("timed out waiting for read data");
    endtask

    task automatic md_op(input logic is_div, input logic cancel);
        wait_instr();
        if (is_div) dec.div_busy <= 1'b1;
        else dec.mul_busy <= 1'b1;
        wait_instr();                        // completes while busy
        dec.mul_busy <= 1'b0;
        dec.div_busy <= 1'b0;
        if (is_div) dec.div_done <= 1'b1;
        else dec.mul_done <= 1'b1;
        @(posedge clk);
        dec.mul_done <= 1'b0;
        dec.div_done <= 1'b0;
        if (cancel) begin
            dec.redirect <= 1'b1;
            dec.target <= 32'h8000_0300;
            @(posedge clk);
            dec.redirect <= 1'b0;
        end
        repeat (2) wait_instr();
    endtask

    initial begin
        void'($urandom(63));
        clk = 1'b0;
        rst_n = 1'b0;
        dec = '0;
        mem = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        repeat (5) wait_instr();
        chk0.finish_test("reset and sequential fetch");
        stall <= 6;
        force_foreign <= 1'b1;
        repeat (3) wait_instr();
        stall <= 0;
        force_foreign <= 1'b0;
        wait_instr();
        chk0.finish_test("id filtering and back-pressure");
        wait_instr();
        dec.lsu_pending <= 1'b1;
        repeat (3) @(posedge clk);
        mem.wb_done <= 1'b1;                 // early, mem_done not seen yet
        @(posedge clk);
        mem.wb_done <= 1'b0;
        @(posedge clk);
        mem.mem_done <= 1'b1;
        @(posedge clk);
        mem.mem_done <= 1'b0;
        repeat (3) @(posedge clk);
        mem.wb_done <= 1'b1;
        dec.lsu_pending <= 1'b0;
        @(posedge clk);
        mem.wb_done <= 1'b0;
        repeat (2) wait_instr();
        chk0.finish_test("memory wait");
        md_op(1'b0, 1'b0);
        md_op(1'b1, 1'b0);
        chk0.finish_test("multiply/divide hold");
        wait_instr();
        dec.redirect <= 1'b1;
        dec.target <= 32'h8000_0100;
        @(posedge clk);
        dec.redirect <= 1'b0;
        wait_data();                         // jalr lands on the fetch_done cycle
        dec.jalr <= 1'b1;
        dec.target <= 32'h8000_0200;
        @(posedge clk);
        dec.jalr <= 1'b0;
        repeat (2) wait_instr();
        md_op(1'b0, 1'b1);
        chk0.finish_test("redirect and jalr");
        chk0.report_counts();
        if (chk0.errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
hdl/cpu_pkg.sv
hdl/bus_pkg.sv
hdl/fetch_sequencer.sv
hdl/muldiv_hold.sv
hdl/pc_update.sv
hdl/fetch_unit.sv
testbench/fetch_unit_assertions.sv
testbench/fetch_checker.sv
testbench/tb_fetch_unit.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_fetch_unit -f list.f
out="$(./obj_dir/Vtb_fetch_unit)"
echo "$out"

if grep -q "=== PASS ===" <<< "$out"; then
    exit 0
else
    exit 1
fi
